/* src/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cache geometry
`define CACHE_N_WAYS        4
`define CACHE_WAY_W         2   // bits to number a way
`define CACHE_SETS_W        4   // 16 sets
`define CACHE_WORD_OFF_W    2   // 4 words per line

// front-end word and address
`define CACHE_ADDR_W        16  // byte address
`define CACHE_DATA_W        32
`define CACHE_NBYTES        4
`define CACHE_BYTE_W        2

// what is left of the address above byte, word and index bits
`define CACHE_TAG_W         8

// write-through buffer holds 2**n entries
`define CACHE_WTBUF_DEPTH_W 2

`endif

/* src/cache_addr_pkg.sv */
`default_nettype none

`include "cache_macros.svh"

package cache_addr_pkg;

   // address fields, word address is split as {tag, index, woff}
   typedef logic [`CACHE_TAG_W-1:0]      tag_t;
   typedef logic [`CACHE_SETS_W-1:0]     index_t;
   typedef logic [`CACHE_WORD_OFF_W-1:0] woff_t;   // word within a line

   typedef logic [`CACHE_ADDR_W-`CACHE_BYTE_W-1:0] waddr_t;   // byte bits dropped

   // line address for refill, word offset dropped too
   typedef logic [`CACHE_ADDR_W-`CACHE_BYTE_W-`CACHE_WORD_OFF_W-1:0] line_addr_t;

   typedef logic [`CACHE_N_WAYS-1:0] way_vec_t;    // one bit per way
   typedef logic [`CACHE_WAY_W-1:0]  way_num_t;    // binary way number
   typedef logic [`CACHE_WAY_W-1:0]  lru_rank_t;   // 0 is least recent

endpackage

`default_nettype wire

/* src/cache_bus_pkg.sv */
`default_nettype none

`include "cache_macros.svh"

package cache_bus_pkg;

   typedef logic [`CACHE_DATA_W-1:0] word_t;
   typedef logic [`CACHE_NBYTES-1:0] strb_t;   // all zero means read

   // one pending write-through transfer
   typedef struct packed {
      cache_addr_pkg::waddr_t addr;
      word_t                  data;
      strb_t                  strb;
   } wtbuf_entry_t;

   typedef enum logic [2:0] {
      IDLE,       // waiting for a request
      LOOKUP,     // arrays read, decide hit or miss
      FILL_REQ,   // drain buffer, then ask for the line
      FILL,       // collecting the four refill words
      RESPOND     // ready high for one cycle
   } ctrl_state_t;

endpackage

`default_nettype wire

/* src/cache_way_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface cache_way_if;

   cache_addr_pkg::index_t   index;            // set read every cycle
   cache_addr_pkg::tag_t     tag;              // tag of the held request
   cache_addr_pkg::woff_t    woff;
   logic                     wr_en;            // write hit update
   cache_bus_pkg::word_t     wdata;
   cache_bus_pkg::strb_t     wstrb;
   logic                     fill_en;          // one refill word this cycle
   cache_addr_pkg::woff_t    fill_woff;
   cache_bus_pkg::word_t     fill_data;
   logic                     lru_update;       // with fill_en marks the last word
   cache_addr_pkg::way_vec_t way_hit;
   cache_bus_pkg::word_t     rdata_line_word;
   cache_addr_pkg::way_vec_t victim;           // one-hot

   modport ctrl (output index, tag, woff, wr_en, wdata, wstrb,
                 output fill_en, fill_woff, fill_data, lru_update,
                 input  way_hit, rdata_line_word);

   modport ways (input  index, tag, woff, wr_en, wdata, wstrb,
                 input  fill_en, fill_woff, fill_data, lru_update, victim,
                 output way_hit, rdata_line_word);

   modport lru (input  index, way_hit, fill_en, lru_update,
                output victim);

endinterface

`default_nettype wire

/* src/cache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cache_ctrl (
   input  wire                               clk,
   input  wire                               rst_n,
   // front end
   input  wire                               valid,
   input  wire cache_addr_pkg::waddr_t       addr,
   input  wire cache_bus_pkg::word_t         wdata,
   input  wire cache_bus_pkg::strb_t         wstrb,
   output logic                              ready,
   output cache_bus_pkg::word_t              rdata,
   cache_way_if.ctrl                         wif,
   // refill channel
   output logic                              replace_valid,
   output cache_addr_pkg::line_addr_t        replace_addr,
   input  wire                               replace_ready,
   input  wire                               read_valid,
   input  wire cache_addr_pkg::woff_t        read_addr,
   input  wire cache_bus_pkg::word_t         read_rdata,
   // write-through buffer
   output logic                              wtbuf_push,
   output cache_bus_pkg::wtbuf_entry_t       wtbuf_entry,
   input  wire                               wtbuf_full,
   input  wire                               wtbuf_empty,
   output logic                              read_hit,
   output logic                              read_miss,
   output logic                              write_hit,
   output logic                              write_miss
);

   cache_bus_pkg::ctrl_state_t state, state_nxt;
   cache_addr_pkg::waddr_t     req_addr, cur_addr;
   cache_bus_pkg::word_t       req_wdata, rdata_q;
   cache_bus_pkg::strb_t       req_wstrb;
   logic                       is_write, hit, hit_q, missed;
   logic [`CACHE_WORD_OFF_W:0] fill_cnt;   // msb set once the line is complete
   logic                       fill_last;

   // in IDLE the arrays are already read at the incoming address
   assign cur_addr = (state == cache_bus_pkg::IDLE) ? addr : req_addr;
   assign is_write = |req_wstrb;
   assign hit      = |wif.way_hit;

   assign wif.index = cur_addr[`CACHE_WORD_OFF_W +: `CACHE_SETS_W];
   assign wif.woff  = cur_addr[`CACHE_WORD_OFF_W-1:0];
   assign wif.tag   = req_addr[`CACHE_ADDR_W-`CACHE_BYTE_W-1 -: `CACHE_TAG_W];
   assign wif.wdata = req_wdata;
   assign wif.wstrb = req_wstrb;

   // each write is pushed once, as LOOKUP is left
   assign wtbuf_push  = (state == cache_bus_pkg::LOOKUP) && is_write && !wtbuf_full;
   assign wtbuf_entry = '{addr: req_addr, data: req_wdata, strb: req_wstrb};
   assign wif.wr_en   = wtbuf_push;   // ways gate this with way_hit

   // refill only after earlier writes have reached memory
   assign replace_valid = (state == cache_bus_pkg::FILL_REQ) && wtbuf_empty;
   assign replace_addr  = req_addr[`CACHE_ADDR_W-`CACHE_BYTE_W-1:`CACHE_WORD_OFF_W];

   assign wif.fill_en   = (state == cache_bus_pkg::FILL) && read_valid;
   assign wif.fill_woff = read_addr;
   assign wif.fill_data = read_rdata;
   assign fill_last     = wif.fill_en &&
                          (fill_cnt == {1'b0, {`CACHE_WORD_OFF_W{1'b1}}});

   // victim rank on the last fill word, hit way rank on a hit
   // a stalled write hit updates once, as it leaves LOOKUP
   assign wif.lru_update = fill_last ||
                           ((state == cache_bus_pkg::LOOKUP) && hit &&
                            (!is_write || !wtbuf_full));

   assign ready      = (state == cache_bus_pkg::RESPOND);
   assign rdata      = rdata_q;
   assign read_hit   = ready && !is_write && hit_q;
   assign read_miss  = ready && !is_write && !hit_q;
   assign write_hit  = ready && is_write && hit_q;
   assign write_miss = ready && is_write && !hit_q;

   always_comb
   begin
      state_nxt = state;
      case (state)
         cache_bus_pkg::IDLE:
            if (valid) state_nxt = cache_bus_pkg::LOOKUP;
         cache_bus_pkg::LOOKUP:
            if (is_write)
            begin
               if (!wtbuf_full) state_nxt = cache_bus_pkg::RESPOND;   // else stall
            end
            else if (hit)
               state_nxt = cache_bus_pkg::RESPOND;
            else
               state_nxt = cache_bus_pkg::FILL_REQ;
         cache_bus_pkg::FILL_REQ:
            if (replace_valid && replace_ready) state_nxt = cache_bus_pkg::FILL;
         cache_bus_pkg::FILL:
            // one spare cycle so the arrays show the new line
            if (fill_cnt[`CACHE_WORD_OFF_W]) state_nxt = cache_bus_pkg::LOOKUP;
         default:
            state_nxt = cache_bus_pkg::IDLE;   // RESPOND
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state    <= cache_bus_pkg::IDLE;
         hit_q    <= 1'b0;
         missed   <= 1'b0;
         fill_cnt <= '0;
      end
      else
      begin
         state <= state_nxt;
         if (state == cache_bus_pkg::IDLE)
            missed <= 1'b0;
         else if ((state == cache_bus_pkg::LOOKUP) && !is_write && !hit)
            missed <= 1'b1;   // answered later from the refilled line
         if (state == cache_bus_pkg::LOOKUP)
            hit_q <= hit && !missed;
         if (state == cache_bus_pkg::FILL_REQ)
            fill_cnt <= '0;
         else if (wif.fill_en)
            fill_cnt <= fill_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if ((state == cache_bus_pkg::IDLE) && valid)
      begin
         req_addr  <= addr;
         req_wdata <= wdata;
         req_wstrb <= wstrb;
      end
      if ((state == cache_bus_pkg::LOOKUP) && hit)
         rdata_q <= wif.rdata_line_word;
   end

endmodule

`default_nettype wire

/* src/cache_ways.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cache_ways (
   input wire        clk,
   input wire        rst_n,
   input wire        invalidate,
   cache_way_if.ways wif
);

   localparam int NSETS  = 1 << `CACHE_SETS_W;
   localparam int NWORDS = 1 << `CACHE_WORD_OFF_W;

   cache_addr_pkg::tag_t     tag_mem  [`CACHE_N_WAYS][NSETS];
   cache_bus_pkg::word_t     data_mem [`CACHE_N_WAYS][NSETS][NWORDS];
   cache_addr_pkg::way_vec_t valid_mem [NSETS];   // bit per way, per set

   cache_addr_pkg::tag_t     tag_q  [`CACHE_N_WAYS];   // set read last cycle
   cache_bus_pkg::word_t     word_q [`CACHE_N_WAYS];
   cache_addr_pkg::way_vec_t valid_q;
   cache_addr_pkg::way_num_t hit_way;
   logic                     line_done;

   assign line_done = wif.fill_en && wif.lru_update;   // last refill word

   // valid bits, cleared by reset or invalidate
   always_ff @(posedge clk)
   begin
      if (!rst_n || invalidate)
      begin
         for (int s = 0; s < NSETS; s++)
            valid_mem[s] <= '0;
         valid_q <= '0;
      end
      else
      begin
         if (line_done)
            valid_mem[wif.index] <= valid_mem[wif.index] | wif.victim;
         valid_q <= valid_mem[wif.index];
      end
   end

   // tag and data arrays
   always_ff @(posedge clk)
   begin
      for (int w = 0; w < `CACHE_N_WAYS; w++)
      begin
         if (wif.wr_en && wif.way_hit[w])
            for (int b = 0; b < `CACHE_NBYTES; b++)
               if (wif.wstrb[b])
                  data_mem[w][wif.index][wif.woff][8*b +: 8] <= wif.wdata[8*b +: 8];
         if (wif.fill_en && wif.victim[w])
            data_mem[w][wif.index][wif.fill_woff] <= wif.fill_data;
         if (line_done && wif.victim[w])
            tag_mem[w][wif.index] <= wif.tag;   // tag lands with the last word
         tag_q[w]  <= tag_mem[w][wif.index];
         word_q[w] <= data_mem[w][wif.index][wif.woff];
      end
   end

   // tag compare against the held request
   always_comb
   begin
      for (int w = 0; w < `CACHE_N_WAYS; w++)
         wif.way_hit[w] = valid_q[w] && (tag_q[w] == wif.tag);
   end

   always_comb
   begin
      hit_way = '0;
      for (int w = 0; w < `CACHE_N_WAYS; w++)
         if (wif.way_hit[w]) hit_way = cache_addr_pkg::way_num_t'(w);
   end

   assign wif.rdata_line_word = word_q[hit_way];

endmodule

`default_nettype wire

/* src/cache_lru.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cache_lru (
   input wire       clk,
   input wire       rst_n,
   input wire       invalidate,
   cache_way_if.lru wif
);

   localparam int NSETS = 1 << `CACHE_SETS_W;

   cache_addr_pkg::lru_rank_t rank_mem [NSETS][`CACHE_N_WAYS];
   cache_addr_pkg::lru_rank_t rank_q   [`CACHE_N_WAYS];   // ranks of current set
   cache_addr_pkg::lru_rank_t rank_nxt [`CACHE_N_WAYS];
   cache_addr_pkg::way_vec_t  acc;                        // way being touched
   cache_addr_pkg::lru_rank_t acc_rank;

   // rank zero is the least recently used way
   always_comb
   begin
      for (int w = 0; w < `CACHE_N_WAYS; w++)
         wif.victim[w] = (rank_q[w] == '0);
   end

   assign acc = wif.fill_en ? wif.victim : wif.way_hit;

   always_comb
   begin
      acc_rank = '0;
      for (int w = 0; w < `CACHE_N_WAYS; w++)
         if (acc[w]) acc_rank = acc_rank | rank_q[w];
      for (int w = 0; w < `CACHE_N_WAYS; w++)
      begin
         if (acc[w])
            rank_nxt[w] = '1;   // most recent
         else if (rank_q[w] > acc_rank)
            rank_nxt[w] = rank_q[w] - 1'b1;   // moves down past the old slot
         else
            rank_nxt[w] = rank_q[w];
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n || invalidate)
      begin
         // way i gets rank i, so way 0 goes first
         for (int s = 0; s < NSETS; s++)
            for (int w = 0; w < `CACHE_N_WAYS; w++)
               rank_mem[s][w] <= cache_addr_pkg::lru_rank_t'(w);
      end
      else if (wif.lru_update)
      begin
         for (int w = 0; w < `CACHE_N_WAYS; w++)
            rank_mem[wif.index][w] <= rank_nxt[w];
      end
   end

   always_ff @(posedge clk)
   begin
      for (int w = 0; w < `CACHE_N_WAYS; w++)
         rank_q[w] <= rank_mem[wif.index][w];
   end

endmodule

`default_nettype wire

/* src/cache_wtbuf.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cache_wtbuf (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire                               push,
   input  wire cache_bus_pkg::wtbuf_entry_t  entry,
   output logic                              full,
   output logic                              empty,
   output logic                              write_valid,
   output cache_addr_pkg::waddr_t            write_addr,
   output cache_bus_pkg::word_t              write_wdata,
   output cache_bus_pkg::strb_t              write_wstrb,
   input  wire                               write_ready
);

   localparam int DEPTH = 1 << `CACHE_WTBUF_DEPTH_W;

   cache_bus_pkg::wtbuf_entry_t       mem [DEPTH];
   logic [`CACHE_WTBUF_DEPTH_W-1:0]   rd_ptr, wr_ptr;
   logic [`CACHE_WTBUF_DEPTH_W:0]     count;   // one extra bit for full
   logic                              pop;

   assign wr_ptr = rd_ptr + count[`CACHE_WTBUF_DEPTH_W-1:0];   // tail follows from head
   assign pop    = write_valid && write_ready;
   assign full   = (count == (`CACHE_WTBUF_DEPTH_W+1)'(DEPTH));
   assign empty  = (count == '0);

   // head entry sits on the write channel
   assign write_valid = !empty;
   assign write_addr  = mem[rd_ptr].addr;
   assign write_wdata = mem[rd_ptr].data;
   assign write_wstrb = mem[rd_ptr].strb;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // none, or both at once
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (push) mem[wr_ptr] <= entry;   // caller never pushes when full
   end

endmodule

`default_nettype wire

/* src/cache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_top (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         invalidate,
   // front end
   input  wire                         valid,
   input  wire cache_addr_pkg::waddr_t addr,
   input  wire cache_bus_pkg::word_t   wdata,
   input  wire cache_bus_pkg::strb_t   wstrb,
   output cache_bus_pkg::word_t        rdata,
   output logic                        ready,
   // back-end write channel
   output logic                        write_valid,
   output cache_addr_pkg::waddr_t      write_addr,
   output cache_bus_pkg::word_t        write_wdata,
   output cache_bus_pkg::strb_t        write_wstrb,
   input  wire                         write_ready,
   // refill channel
   output logic                        replace_valid,
   output cache_addr_pkg::line_addr_t  replace_addr,
   input  wire                         replace_ready,
   input  wire                         read_valid,
   input  wire cache_addr_pkg::woff_t  read_addr,
   input  wire cache_bus_pkg::word_t   read_rdata,
   // status
   output logic                        wtbuf_full,
   output logic                        wtbuf_empty,
   output logic                        read_hit,
   output logic                        read_miss,
   output logic                        write_hit,
   output logic                        write_miss
);

   logic                        wtbuf_push;
   cache_bus_pkg::wtbuf_entry_t wtbuf_entry;

   cache_way_if wif ();   // ctrl, ways and lru share it

   cache_ctrl u_ctrl (.*);

   cache_ways u_ways (
      .clk        (clk),
      .rst_n      (rst_n),
      .invalidate (invalidate),
      .wif        (wif)
   );

   cache_lru u_lru (
      .clk        (clk),
      .rst_n      (rst_n),
      .invalidate (invalidate),
      .wif        (wif)
   );

   cache_wtbuf u_wtbuf (
      .clk         (clk),
      .rst_n       (rst_n),
      .push        (wtbuf_push),
      .entry       (wtbuf_entry),
      .full        (wtbuf_full),
      .empty       (wtbuf_empty),
      .write_valid (write_valid),
      .write_addr  (write_addr),
      .write_wdata (write_wdata),
      .write_wstrb (write_wstrb),
      .write_ready (write_ready)
   );

endmodule

`default_nettype wire

/* dv/cache_top_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_top_chk (
   input wire clk,
   input wire rst_n,
   input wire valid,
   input wire ready,
   input wire replace_valid,
   input wire replace_ready,
   input wire write_valid,
   input wire wtbuf_push,
   input wire read_hit,
   input wire read_miss,
   input wire write_hit,
   input wire write_miss
);

   logic pushed;      // a write has entered the buffer since reset
   int   fails = 0;   // assertions that fired

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         pushed <= 1'b0;
      else if (wtbuf_push)
         pushed <= 1'b1;
   end

   // refill request stays up until the memory takes it
   replace_hold: assert property (@(posedge clk) disable iff (!rst_n)
      replace_valid && !replace_ready |=> replace_valid)
      else
      begin
         fails++;
         $error("replace_valid dropped before replace_ready");
      end

   wv_after_push: assert property (@(posedge clk) disable iff (!rst_n)
      !pushed |-> !write_valid)
      else
      begin
         fails++;
         $error("write_valid before any push");
      end

   ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
      ready |-> valid)
      else
      begin
         fails++;
         $error("ready without valid");
      end

   one_status: assert property (@(posedge clk) disable iff (!rst_n)
      ready |-> $onehot({read_hit, read_miss, write_hit, write_miss}))
      else
      begin
         fails++;
         $error("not exactly one hit or miss pulse with ready");
      end

endmodule

bind cache_top cache_top_chk u_chk (.*);

`default_nettype wire

/* dv/cache_top_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_top_tb;

   localparam int N_REQ  = 360;   // all requests of all tests, rounded up
   localparam int NWORDS = 1 << 14;

   logic clk;
   logic rst_n;
   logic invalidate;
   logic valid;
   logic ready;
   logic write_valid;
   logic write_ready;
   logic replace_valid;
   logic replace_ready;
   logic read_valid;
   logic wtbuf_full;
   logic wtbuf_empty;
   logic read_hit;
   logic read_miss;
   logic write_hit;
   logic write_miss;
   cache_addr_pkg::waddr_t     addr;
   cache_addr_pkg::waddr_t     write_addr;
   cache_addr_pkg::line_addr_t replace_addr;
   cache_addr_pkg::woff_t      read_addr;
   cache_bus_pkg::word_t       wdata;
   cache_bus_pkg::word_t       rdata;
   cache_bus_pkg::word_t       write_wdata;
   cache_bus_pkg::word_t       read_rdata;
   cache_bus_pkg::strb_t       wstrb;
   cache_bus_pkg::strb_t       write_wstrb;

   // reference model state
   cache_bus_pkg::word_t        shadow [NWORDS];   // what every read must return
   cache_bus_pkg::word_t        bmem   [NWORDS];   // back-end memory
   cache_addr_pkg::tag_t        m_tag  [16][4];
   logic                        m_val  [16][4];
   int                          m_rank [16][4];
   cache_bus_pkg::wtbuf_entry_t wq [$];            // writes still owed to the back end

   logic [31:0] stim_seed;
   logic [31:0] be_seed;
   bit          exp_hit;
   bit          exp_write;
   bit          chk_lat;
   cache_bus_pkg::word_t exp_rdata;
   int          ncyc;
   int          issue_n;
   int          errors;
   int          checks;
   int          tests;
   int          err0;
   bit          hold_wr;                           // forces write_ready low
   bit          fill_on;
   cache_addr_pkg::line_addr_t fill_line;
   cache_addr_pkg::woff_t      order [4];           // refill word order
   cache_addr_pkg::woff_t      tmp_woff;
   int          fill_idx;
   int          j;
   logic [14:0] r;
   cache_addr_pkg::waddr_t ra;
   cache_bus_pkg::strb_t   rs;

   cache_top u_cache_top (.*);

   always #4 clk = ~clk;

   function automatic cache_bus_pkg::word_t pattern(input cache_addr_pkg::waddr_t a);
      return {a, 2'b01, ~a, 2'b10};   // every address bit shows up
   endfunction

   function automatic logic [14:0] lcg_next(inout logic [31:0] st);
      st = st * 32'd1103515245 + 32'd12345;
      return st[30:16];
   endfunction

   function automatic void model_reset();
      for (int s = 0; s < 16; s++)
         for (int w = 0; w < 4; w++)
         begin
            m_val[s][w]  = 1'b0;
            m_rank[s][w] = w;   // way 0 is the first victim
         end
   endfunction

   // accessed way goes to rank 3, ways above its old rank move down
   function automatic void touch(input int s, input int w);
      int old;
      old = m_rank[s][w];
      for (int v = 0; v < 4; v++)
         if (m_rank[s][v] > old) m_rank[s][v] = m_rank[s][v] - 1;
      m_rank[s][w] = 3;
   endfunction

   // predicts hit and read data, and moves the model one request on
   function automatic void ref_access(input cache_addr_pkg::waddr_t a,
                                      input cache_bus_pkg::word_t d,
                                      input cache_bus_pkg::strb_t st,
                                      output bit hit, output cache_bus_pkg::word_t rd);
      int s;
      int hw;
      s   = int'(a[5:2]);
      hit = 1'b0;
      hw  = 0;
      for (int w = 0; w < 4; w++)
         if (m_val[s][w] && m_tag[s][w] == a[13:6])
         begin
            hit = 1'b1;
            hw  = w;
         end
      rd = '0;
      if (st == '0)
      begin
         if (!hit)   // refill goes to the rank-zero way
         begin
            for (int w = 0; w < 4; w++)
               if (m_rank[s][w] == 0) hw = w;
            m_tag[s][hw] = a[13:6];
            m_val[s][hw] = 1'b1;
         end
         touch(s, hw);
         rd = shadow[a];
      end
      else
      begin
         if (hit) touch(s, hw);   // no allocation on a write miss
         for (int b = 0; b < 4; b++)
            if (st[b]) shadow[a][8*b +: 8] = d[8*b +: 8];
      end
   endfunction

   task automatic report(input string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic start_req(input cache_addr_pkg::waddr_t a, input cache_bus_pkg::word_t d,
                            input cache_bus_pkg::strb_t st, input bit lat);
      bit                   h;
      cache_bus_pkg::word_t rd;
      @(posedge clk);
      ref_access(a, d, st, h, rd);
      exp_hit   = h;
      exp_rdata = rd;
      exp_write = (st != '0);
      chk_lat   = lat;
      issue_n   = ncyc;
      if (exp_write) wq.push_back('{addr: a, data: d, strb: st});
      valid <= 1'b1;
      addr  <= a;
      wdata <= d;
      wstrb <= st;
   endtask

   task automatic finish_req();
      do @(negedge clk); while (!ready);
      @(posedge clk);
      valid <= 1'b0;
   endtask

   task automatic access(input cache_addr_pkg::waddr_t a, input cache_bus_pkg::word_t d,
                         input cache_bus_pkg::strb_t st, input bit lat);
      start_req(a, d, st, lat);
      finish_req();
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %-14s %s, %0d errors", name, (errors == err0) ? "ok" : "FAILED",
               errors - err0);
      err0 = errors;
   endtask

   // compare each completed request against the reference
   always @(negedge clk)
   begin
      ncyc = ncyc + 1;
      if (rst_n && ready)
      begin
         checks++;
         if (exp_write)
            assert (write_hit == exp_hit && write_miss == !exp_hit && !read_hit && !read_miss)
            else report($sformatf("write %h hit %b expected %b", addr, write_hit, exp_hit));
         else
         begin
            assert (read_hit == exp_hit && read_miss == !exp_hit && !write_hit && !write_miss)
            else report($sformatf("read %h hit %b expected %b", addr, read_hit, exp_hit));
            assert (rdata == exp_rdata)
            else report($sformatf("read %h data %h expected %h", addr, rdata, exp_rdata));
         end
         if (chk_lat)
            assert (ncyc - issue_n - 1 == 2)
            else report($sformatf("ready %0d cycles after valid", ncyc - issue_n - 1));
      end
   end

   // back-end memory, write channel and refill
   always
   begin
      @(negedge clk);
      if (rst_n && write_valid && write_ready)
      begin
         assert (wq.size() > 0 && wq[0] == {write_addr, write_wdata, write_wstrb})
         else report($sformatf("unexpected write %h %h %b", write_addr, write_wdata,
                               write_wstrb));
         if (wq.size() > 0) void'(wq.pop_front());
         for (int b = 0; b < 4; b++)
            if (write_wstrb[b]) bmem[write_addr][8*b +: 8] = write_wdata[8*b +: 8];
      end
      if (rst_n && !fill_on && replace_valid && replace_ready)
      begin
         fill_on   = 1'b1;
         fill_line = replace_addr;
         fill_idx  = 0;
         for (int i = 0; i < 4; i++)
            order[i] = cache_addr_pkg::woff_t'(i);
         for (int i = 3; i > 0; i--)   // shuffle
         begin
            j        = int'(lcg_next(be_seed)) % (i + 1);
            tmp_woff = order[i];
            order[i] = order[j];
            order[j] = tmp_woff;
         end
      end
      @(posedge clk);
      write_ready   <= hold_wr ? 1'b0 : (lcg_next(be_seed) % 4 != 0);
      replace_ready <= lcg_next(be_seed) % 2 != 0;
      if (fill_on && fill_idx == 4)
      begin
         read_valid <= 1'b0;
         fill_on = 1'b0;
      end
      else if (fill_on && lcg_next(be_seed) % 3 != 0)   // else a gap
      begin
         read_valid <= 1'b1;
         read_addr  <= order[fill_idx];
         read_rdata <= bmem[{fill_line, order[fill_idx]}];
         fill_idx++;
      end
      else
         read_valid <= 1'b0;
   end

   initial
   begin
      #(N_REQ * 200 * 8);
      $display("timeout, requests did not finish within the cycle budget");
      $display("Test failed");
      $finish;
   end

   initial
   begin
      clk = 1'b0;
      rst_n = 1'b0;
      invalidate = 1'b0;
      valid = 1'b0;
      addr = '0;
      wdata = '0;
      wstrb = '0;
      write_ready = 1'b0;
      replace_ready = 1'b0;
      read_valid = 1'b0;
      read_addr = '0;
      read_rdata = '0;
      stim_seed = 32'd35825;
      be_seed = 32'd35825;
      hold_wr = 1'b0;
      fill_on = 1'b0;
      errors = 0;
      checks = 0;
      tests = 0;
      err0 = 0;
      ncyc = 0;
      for (int a = 0; a < NWORDS; a++)
      begin
         shadow[a] = pattern(cache_addr_pkg::waddr_t'(a));
         bmem[a]   = pattern(cache_addr_pkg::waddr_t'(a));
      end
      model_reset();
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      for (int i = 0; i < 4; i++)   // cold misses, then hits with latency check
         access(14'h0040 + 14'(i * 5), '0, '0, 1'b0);
      for (int i = 0; i < 4; i++)
         access(14'h0040 + 14'(i * 5), '0, '0, 1'b1);
      end_test("reset_hit");

      access(14'h0100, '0, '0, 1'b0);
      access(14'h0101, 32'ha5a5_5a5a, 4'b0110, 1'b0);   // write hit
      access(14'h0101, '0, '0, 1'b0);
      access(14'h2203, 32'h1234_5678, 4'b1001, 1'b0);   // write miss
      access(14'h2203, '0, '0, 1'b0);
      end_test("write_through");

      for (int t = 0; t < 5; t++)   // five tags in set 9
         access({8'(8'h40 + t), 4'h9, 2'b01}, '0, '0, 1'b0);
      access({8'h40, 4'h9, 2'b01}, '0, '0, 1'b0);
      for (int t = 4; t > 1; t--)
         access({8'(8'h40 + t), 4'h9, 2'b01}, '0, '0, 1'b0);
      end_test("lru_evict");

      while (!wtbuf_empty) @(negedge clk);
      hold_wr = 1'b1;
      repeat (2) @(posedge clk);
      for (int i = 0; i < 4; i++)
         access(14'h3000 + 14'(i * 4), 32'hc0de_0000 + i, 4'hf, 1'b0);
      start_req(14'h3010, 32'hc0de_0004, 4'hf, 1'b0);   // fifth write stalls
      repeat (8)
      begin
         @(negedge clk);
         assert (!ready && wtbuf_full) else report("fifth write not held by full buffer");
      end
      hold_wr = 1'b0;
      finish_req();
      while (!wtbuf_empty) @(negedge clk);   // room for the next write
      hold_wr = 1'b1;
      repeat (2) @(posedge clk);
      access(14'h3100, 32'hbeef_0001, 4'b0011, 1'b0);
      start_req(14'h3100, '0, '0, 1'b0);   // read miss behind a pending write
      repeat (8)
      begin
         @(negedge clk);
         assert (!replace_valid) else report("refill requested before buffer drained");
         assert (!wtbuf_empty) else report("write buffer shows empty with a write pending");
      end
      hold_wr = 1'b0;
      finish_req();
      end_test("back_pressure");

      @(posedge clk);
      invalidate <= 1'b1;
      @(posedge clk);
      invalidate <= 1'b0;
      model_reset();
      for (int t = 0; t < 5; t++)
         access({8'(8'h40 + t), 4'h9, 2'b01}, '0, '0, 1'b0);
      access(14'h0101, '0, '0, 1'b0);
      end_test("invalidate");

      for (int n = 0; n < 300; n++)   // 64 lines over 8 sets
      begin
         r  = lcg_next(stim_seed);
         ra = {5'b0, r[5:3], 1'b0, r[2:0], r[7:6]};
         rs = r[8] ? ((r[12:9] == '0) ? 4'hf : r[12:9]) : 4'h0;
         access(ra, {lcg_next(stim_seed), lcg_next(stim_seed)}, rs, 1'b0);
      end
      end_test("random_mix");

      while (!wtbuf_empty) @(negedge clk);
      repeat (4) @(negedge clk);
      assert (wq.size() == 0) else report($sformatf("%0d writes never reached memory",
                                                    wq.size()));
      errors = errors + u_cache_top.u_chk.fails;   // bound protocol assertions
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* cache_top.f */
+incdir+src
src/cache_addr_pkg.sv
src/cache_bus_pkg.sv
src/cache_way_if.sv
src/cache_ctrl.sv
src/cache_ways.sv
src/cache_lru.sv
src/cache_wtbuf.sv
src/cache_top.sv
dv/cache_top_chk.sv
dv/cache_top_tb.sv

/* Makefile */
TOP = cache_top_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f cache_top.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir
